/* verilog/eeprom_settings.svh */
`ifndef EEPROM_SETTINGS_SVH
`define EEPROM_SETTINGS_SVH

// byte address and transfer length
`define EE_ADDR_W        16
`define EE_LEN_W         17

// serial phase lengths in sys_clk cycles
`define EE_CMD_CYCLES    18
`define EE_ADDR_CYCLES   32
`define EE_BYTE_CYCLES   16

// host write byte buffer
`define EE_TXFIFO_DEPTH  16

`endif

/* verilog/eeprom_pkg.sv */
`default_nettype none

`include "eeprom_settings.svh"

package eeprom_pkg;

  typedef enum logic [7:0]
  {
    OP_WREN  = 8'h06,
    OP_RDSR  = 8'h05,
    OP_READ  = 8'h03,
    OP_WRITE = 8'h02
  } spi_opcode_e;

  typedef enum logic [2:0]
  {
    ST_IDLE,
    ST_LOAD,
    ST_CMD,
    ST_STATUS,
    ST_ADDR,
    ST_RD_DATA,
    ST_WR_DATA
  } seq_state_e;

  typedef struct packed
  {
    spi_opcode_e           opcode;
    logic [`EE_ADDR_W-1:0] addr;
    logic [`EE_LEN_W-1:0]  len;
  } ee_req_t;

  // one array access, valid while a strobe is high
  typedef struct packed
  {
    logic                  wr_strobe;
    logic                  rd_strobe;
    logic [`EE_ADDR_W-1:0] addr;
    logic [7:0]            data;
    logic                  last;
    logic                  status_rd;
  } ee_mem_op_t;

endpackage

`default_nettype wire

/* verilog/eeprom_req_decode.sv */
`timescale 1ns/100ps
`default_nettype none

`include "eeprom_settings.svh"

module eeprom_req_decode
  import eeprom_pkg::*;
(
  input  logic                  sys_clk,
  input  logic                  glbl_rst_n,
  input  logic                  flash_rden,
  input  logic                  flash_wren,
  input  logic [`EE_ADDR_W:0]   flash_addr,
  input  logic [`EE_LEN_W-1:0]  flash_length,
  input  logic                  seq_idle,
  output logic                  flash_ready,
  output ee_req_t               req,
  output logic                  req_valid
);

  logic        req_pending;
  logic        new_req;
  spi_opcode_e opcode;

  assign new_req = flash_rden || flash_wren;

  // low from the request pulse until the sequencer is idle again
  assign flash_ready = seq_idle && !req_pending && !new_req;

  // bit 16 selects the register space
  always_comb
  begin
    if (flash_addr[`EE_ADDR_W])
      opcode = flash_wren ? OP_WREN : OP_RDSR;
    else
      opcode = flash_wren ? OP_WRITE : OP_READ;
  end

  always_ff @(posedge sys_clk)
  begin
    if (!glbl_rst_n)
    begin
      req_pending <= 1'b0;
      req_valid   <= 1'b0;
    end
    else
    begin
      req_valid <= new_req;
      if (new_req)
        req_pending <= 1'b1;
      else if (!seq_idle)
        req_pending <= 1'b0;
    end
  end

  always_ff @(posedge sys_clk)
  begin
    if (new_req)
    begin
      req.opcode <= opcode;
      req.addr   <= flash_addr[`EE_ADDR_W-1:0];
      req.len    <= flash_length;
    end
  end

endmodule

`default_nettype wire

/* verilog/eeprom_tx_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

`include "eeprom_settings.svh"

module eeprom_tx_fifo
(
  input  logic       sys_clk,
  input  logic       glbl_rst_n,
  input  logic       wr_valid,
  input  logic [7:0] wr_data,
  input  logic       fifo_pop,
  output logic [7:0] fifo_data,
  output logic       fifo_empty
);

  localparam int PTR_W = $clog2(`EE_TXFIFO_DEPTH);

  logic [7:0]     buf_mem [`EE_TXFIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             in_valid;
  logic [7:0]       in_data;
  logic             push;
  logic             pop;

  assign fifo_empty = (count == '0);
  assign fifo_data  = buf_mem[rd_ptr];

  // drop on full
  assign push = in_valid && (count != (PTR_W + 1)'(`EE_TXFIFO_DEPTH));
  assign pop  = fifo_pop && !fifo_empty;

  always_ff @(posedge sys_clk)
  begin
    if (!glbl_rst_n)
    begin
      in_valid <= 1'b0;
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
    end
    else
    begin
      in_valid <= wr_valid;
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      count <= count + (PTR_W + 1)'(push) - (PTR_W + 1)'(pop);
    end
  end

  always_ff @(posedge sys_clk)
  begin
    in_data <= wr_data;
    if (push)
      buf_mem[wr_ptr] <= in_data;
  end

endmodule

`default_nettype wire

/* verilog/eeprom_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "eeprom_settings.svh"

module eeprom_sequencer
  import eeprom_pkg::*;
(
  input  logic       sys_clk,
  input  logic       glbl_rst_n,
  input  ee_req_t    req,
  input  logic       req_valid,
  input  logic [7:0] fifo_data,
  input  logic       fifo_empty,
  output logic       seq_idle,
  output logic       fifo_pop,
  output ee_mem_op_t mem_op,
  output logic       wel_set,
  output logic       wel_clear
);

  localparam int PH_W   = $clog2(`EE_ADDR_CYCLES);
  localparam int SLOT_W = $clog2(`EE_BYTE_CYCLES);

  seq_state_e            state;
  ee_req_t               req_q;
  logic [PH_W-1:0]       phase_cnt;
  logic [SLOT_W-1:0]     slot_cnt;
  logic [`EE_LEN_W-1:0]  byte_cnt;
  logic [`EE_ADDR_W-1:0] addr_q;
  logic                  cmd_done;
  logic                  status_done;
  logic                  addr_done;
  logic                  slot_last;
  logic                  last_byte;
  logic                  byte_step;

  assign cmd_done    = (phase_cnt == PH_W'(`EE_CMD_CYCLES - 1));
  assign status_done = (phase_cnt == PH_W'(`EE_BYTE_CYCLES - 1));
  assign addr_done   = (phase_cnt == PH_W'(`EE_ADDR_CYCLES - 1));
  assign slot_last   = (slot_cnt == SLOT_W'(`EE_BYTE_CYCLES - 1));
  assign last_byte   = (byte_cnt == req_q.len - 1'b1);

  assign seq_idle  = (state == ST_IDLE);
  assign fifo_pop  = (state == ST_WR_DATA) && slot_last && !fifo_empty;
  assign byte_step = ((state == ST_RD_DATA) && slot_last) || fifo_pop;
  assign wel_set   = (state == ST_CMD) && cmd_done && (req_q.opcode == OP_WREN);
  assign wel_clear = fifo_pop && last_byte;

  always_comb
  begin
    mem_op           = '0;
    mem_op.addr      = addr_q;
    mem_op.data      = fifo_data;
    mem_op.last      = last_byte;
    mem_op.wr_strobe = fifo_pop;
    mem_op.rd_strobe = ((state == ST_RD_DATA) && slot_last) ||
                       ((state == ST_STATUS) && status_done);
    mem_op.status_rd = (state == ST_STATUS);
  end

  always_ff @(posedge sys_clk)
  begin
    if (!glbl_rst_n)
    begin
      state     <= ST_IDLE;
      phase_cnt <= '0;
      slot_cnt  <= '0;
      byte_cnt  <= '0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          if (req_valid)
            state <= ST_LOAD;
        end
        ST_LOAD:
        begin
          state     <= ST_CMD;
          phase_cnt <= '0;
        end
        ST_CMD:
        begin
          phase_cnt <= phase_cnt + 1'b1;
          if (cmd_done)
          begin
            phase_cnt <= '0;
            case (req_q.opcode)
              OP_WREN: state <= ST_IDLE;
              OP_RDSR: state <= ST_STATUS;
              default: state <= ST_ADDR;
            endcase
          end
        end
        ST_STATUS:
        begin
          phase_cnt <= phase_cnt + 1'b1;
          if (status_done)
            state <= ST_IDLE;
        end
        ST_ADDR:
        begin
          phase_cnt <= phase_cnt + 1'b1;
          slot_cnt  <= '0;
          byte_cnt  <= '0;
          if (addr_done)
            state <= (req_q.opcode == OP_WRITE) ? ST_WR_DATA : ST_RD_DATA;
        end
        ST_RD_DATA, ST_WR_DATA:
        begin
          // slot holds at its pop cycle while the fifo is empty
          if (!slot_last)
            slot_cnt <= slot_cnt + 1'b1;
          else if (byte_step)
          begin
            slot_cnt <= '0;
            byte_cnt <= byte_cnt + 1'b1;
            if (last_byte)
              state <= ST_IDLE;
          end
        end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge sys_clk)
  begin
    if ((state == ST_IDLE) && req_valid)
      req_q <= req;
    if (state == ST_LOAD)
      addr_q <= req_q.addr;
    else if (byte_step)
      addr_q <= addr_q + 1'b1;
  end

endmodule

`default_nettype wire

/* verilog/eeprom_array.sv */
`timescale 1ns/100ps
`default_nettype none

`include "eeprom_settings.svh"

module eeprom_array
  import eeprom_pkg::*;
(
  input  logic       sys_clk,
  input  ee_mem_op_t mem_op,
  input  logic       wel_set,
  input  logic       wel_clear,
  input  logic       glbl_rst_n,
  output ee_mem_op_t ret_op,
  output logic [7:0] rd_byte
);

  logic [7:0] mem [2**`EE_ADDR_W];
  logic       wel;
  logic       wip;
  logic [7:0] status_byte;

  assign status_byte = {6'd0, wel, wip};

  always_ff @(posedge sys_clk)
  begin
    if (!glbl_rst_n)
    begin
      wel    <= 1'b0;
      wip    <= 1'b0;
      ret_op <= '0;
    end
    else
    begin
      ret_op <= mem_op;
      if (wel_set)
        wel <= 1'b1;
      else if (wel_clear)
        wel <= 1'b0;
      // wip marks a stored write and clears on a new enable
      if (wel_set)
        wip <= 1'b0;
      else if (mem_op.wr_strobe && wel)
        wip <= 1'b1;
    end
  end

  always_ff @(posedge sys_clk)
  begin
    if (mem_op.wr_strobe && wel)
      mem[mem_op.addr] <= mem_op.data;
    if (mem_op.rd_strobe)
      rd_byte <= mem_op.status_rd ? status_byte : mem[mem_op.addr];
  end

endmodule

`default_nettype wire

/* verilog/eeprom_read_return.sv */
`timescale 1ns/100ps
`default_nettype none

module eeprom_read_return
  import eeprom_pkg::*;
(
  input  logic       sys_clk,
  input  logic       glbl_rst_n,
  input  ee_mem_op_t ret_op,
  input  logic [7:0] rd_byte,
  output logic [7:0] flash_rd_data,
  output logic       flash_rd_valid,
  output logic       flash_rd_last,
  output logic       status_reg_en,
  output logic [7:0] status_reg
);

  logic data_ret;
  logic status_ret;

  // split the returned read by kind
  assign data_ret   = ret_op.rd_strobe && !ret_op.status_rd;
  assign status_ret = ret_op.rd_strobe && ret_op.status_rd;

  always_ff @(posedge sys_clk)
  begin
    if (!glbl_rst_n)
    begin
      flash_rd_valid <= 1'b0;
      flash_rd_last  <= 1'b0;
      status_reg_en  <= 1'b0;
    end
    else
    begin
      flash_rd_valid <= data_ret;
      flash_rd_last  <= data_ret && ret_op.last;
      status_reg_en  <= status_ret;
    end
  end

  always_ff @(posedge sys_clk)
  begin
    if (data_ret)
      flash_rd_data <= rd_byte;
    if (status_ret)
      status_reg <= rd_byte;
  end

endmodule

`default_nettype wire

/* verilog/eeprom_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "eeprom_settings.svh"

module eeprom_top
  import eeprom_pkg::*;
(
  input  logic                 sys_clk,
  input  logic                 glbl_rst_n,
  input  logic                 flash_rden,
  input  logic                 flash_wren,
  input  logic [`EE_ADDR_W:0]  flash_addr,
  input  logic [`EE_LEN_W-1:0] flash_length,
  output logic                 flash_ready,
  input  logic [7:0]           flash_wr_data,
  input  logic                 flash_wr_valid,
  input  logic                 flash_wr_last,
  output logic [7:0]           flash_rd_data,
  output logic                 flash_rd_valid,
  output logic                 flash_rd_last,
  output logic                 status_reg_en,
  output logic [7:0]           status_reg
);

  ee_req_t    req;
  logic       req_valid;
  logic       seq_idle;
  logic [7:0] fifo_data;
  logic       fifo_empty;
  logic       fifo_pop;
  ee_mem_op_t mem_op;
  ee_mem_op_t ret_op;
  logic       wel_set;
  logic       wel_clear;
  logic [7:0] rd_byte;

  eeprom_req_decode i_req_decode
  (
    .sys_clk      (sys_clk),
    .glbl_rst_n   (glbl_rst_n),
    .flash_rden   (flash_rden),
    .flash_wren   (flash_wren),
    .flash_addr   (flash_addr),
    .flash_length (flash_length),
    .seq_idle     (seq_idle),
    .flash_ready  (flash_ready),
    .req          (req),
    .req_valid    (req_valid)
  );

  // write bytes are counted by length, flash_wr_last is not needed
  eeprom_tx_fifo i_tx_fifo
  (
    .sys_clk    (sys_clk),
    .glbl_rst_n (glbl_rst_n),
    .wr_valid   (flash_wr_valid),
    .wr_data    (flash_wr_data),
    .fifo_pop   (fifo_pop),
    .fifo_data  (fifo_data),
    .fifo_empty (fifo_empty)
  );

  eeprom_sequencer i_sequencer
  (
    .sys_clk    (sys_clk),
    .glbl_rst_n (glbl_rst_n),
    .req        (req),
    .req_valid  (req_valid),
    .fifo_data  (fifo_data),
    .fifo_empty (fifo_empty),
    .seq_idle   (seq_idle),
    .fifo_pop   (fifo_pop),
    .mem_op     (mem_op),
    .wel_set    (wel_set),
    .wel_clear  (wel_clear)
  );

  eeprom_array i_array
  (
    .sys_clk    (sys_clk),
    .mem_op     (mem_op),
    .wel_set    (wel_set),
    .wel_clear  (wel_clear),
    .glbl_rst_n (glbl_rst_n),
    .ret_op     (ret_op),
    .rd_byte    (rd_byte)
  );

  eeprom_read_return i_read_return
  (
    .sys_clk        (sys_clk),
    .glbl_rst_n     (glbl_rst_n),
    .ret_op         (ret_op),
    .rd_byte        (rd_byte),
    .flash_rd_data  (flash_rd_data),
    .flash_rd_valid (flash_rd_valid),
    .flash_rd_last  (flash_rd_last),
    .status_reg_en  (status_reg_en),
    .status_reg     (status_reg)
  );

endmodule

`default_nettype wire

/* testbench/eeprom_tb_model.svh */
`ifndef EEPROM_TB_MODEL_SVH
`define EEPROM_TB_MODEL_SVH

// reference contents, only bytes that were really stored
logic [7:0] ref_mem [bit [15:0]];
logic       ref_wel;
logic       ref_wip;

function automatic void clear_reference();
  ref_mem.delete();
  ref_wel = 1'b0;
  ref_wip = 1'b0;
endfunction

// enable command sets the latch and starts wip clean
function automatic void apply_write_enable();
  ref_wel = 1'b1;
  ref_wip = 1'b0;
endfunction

function automatic void apply_write(input logic [15:0] addr, input logic [7:0] data);
  if (ref_wel)
  begin
    ref_mem[addr] = data;
    ref_wip       = 1'b1;
  end
endfunction

// every write command drops the latch at its end
function automatic void close_write();
  ref_wel = 1'b0;
endfunction

function automatic logic byte_known(input logic [15:0] addr);
  return ref_mem.exists(addr);
endfunction

function automatic logic [7:0] expected_byte(input logic [15:0] addr);
  return ref_mem[addr];
endfunction

function automatic logic [7:0] expected_status();
  return {6'd0, ref_wel, ref_wip};
endfunction

`endif

/* testbench/eeprom_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "eeprom_settings.svh"

module eeprom_tb;

  localparam int CLK_PERIOD = 20;
  localparam int TX_CYCLES  = `EE_CMD_CYCLES + 2 + `EE_ADDR_CYCLES + `EE_BYTE_CYCLES * 9;
  localparam int TX_TOTAL   = 66;
  localparam int CMD_BUSY   = 2 + `EE_CMD_CYCLES;
  localparam int DATA_BUSY  = CMD_BUSY + `EE_ADDR_CYCLES;
  localparam logic [15:0] WIN_BASE = 16'h0400;

  logic                 sys_clk;
  logic                 glbl_rst_n;
  logic                 flash_rden;
  logic                 flash_wren;
  logic [`EE_ADDR_W:0]  flash_addr;
  logic [`EE_LEN_W-1:0] flash_length;
  logic                 flash_ready;
  logic [7:0]           flash_wr_data;
  logic                 flash_wr_valid;
  logic                 flash_wr_last;
  logic [7:0]           flash_rd_data;
  logic                 flash_rd_valid;
  logic                 flash_rd_last;
  logic                 status_reg_en;
  logic [7:0]           status_reg;

  int          cycle_cnt;
  logic [7:0]  wr_bytes [8];
  logic [7:0]  rd_q [$];
  logic        rd_last_q [$];
  logic [7:0]  st_q [$];
  logic [15:0] used_addr [4];
  int          used_len [4];

  `include "eeprom_tb_model.svh"

  eeprom_top i_dut
  (
    .sys_clk        (sys_clk),
    .glbl_rst_n     (glbl_rst_n),
    .flash_rden     (flash_rden),
    .flash_wren     (flash_wren),
    .flash_addr     (flash_addr),
    .flash_length   (flash_length),
    .flash_ready    (flash_ready),
    .flash_wr_data  (flash_wr_data),
    .flash_wr_valid (flash_wr_valid),
    .flash_wr_last  (flash_wr_last),
    .flash_rd_data  (flash_rd_data),
    .flash_rd_valid (flash_rd_valid),
    .flash_rd_last  (flash_rd_last),
    .status_reg_en  (status_reg_en),
    .status_reg     (status_reg)
  );

  always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

  // collect returned bytes and status as they leave the DUT
  always @(posedge sys_clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (flash_rd_valid)
    begin
      rd_q.push_back(flash_rd_data);
      rd_last_q.push_back(flash_rd_last);
    end
    if (status_reg_en)
      st_q.push_back(status_reg);
  end

  task automatic halt_run(input string line);
    $display("%s", line);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
    else
      halt_run($sformatf("error %s: expected %0h, actual %0h", name, expected, actual));
  endtask

  task automatic issue_request(input logic wr, input logic [`EE_ADDR_W:0] addr,
                               input int len, output int t0);
    @(negedge sys_clk);
    while (!flash_ready)
      @(negedge sys_clk);
    t0 = cycle_cnt;
    @(posedge sys_clk);
    flash_wren   <= wr;
    flash_rden   <= !wr;
    flash_addr   <= addr;
    flash_length <= `EE_LEN_W'(len);
    @(posedge sys_clk);
    flash_wren <= 1'b0;
    flash_rden <= 1'b0;
  endtask

  // cycles with ready low, counted from the request edge
  task automatic wait_idle(input int t0, output int busy);
    @(negedge sys_clk);
    while (!flash_ready)
      @(negedge sys_clk);
    busy = cycle_cnt - t0 - 2;
  endtask

  task automatic write_enable(input string name);
    int t0;
    int busy;
    issue_request(1'b1, {1'b1, 16'h0000}, 1, t0);
    wait_idle(t0, busy);
    check_equal({name, " busy cycles"}, CMD_BUSY, busy);
    apply_write_enable();
  endtask

  task automatic read_status(input string name, output logic [7:0] st);
    int t0;
    int busy;
    int n;
    st_q.delete();
    issue_request(1'b0, {1'b1, 16'h0000}, 1, t0);
    wait_idle(t0, busy);
    check_equal({name, " busy cycles"}, CMD_BUSY + `EE_BYTE_CYCLES, busy);
    n = 0;
    while (st_q.size() == 0 && n < `EE_BYTE_CYCLES)
    begin
      @(negedge sys_clk);
      n++;
    end
    // status trails its read by two cycles
    repeat (2) @(negedge sys_clk);
    check_equal({name, " status count"}, 1, st_q.size());
    st = st_q[0];
    check_equal({name, " status"}, expected_status(), st);
  endtask

  task automatic write_bytes(input string name, input logic [15:0] addr, input int len);
    int t0;
    int busy;
    int i;
    for (i = 0; i < len; i++)
      wr_bytes[i] = 8'($urandom);
    issue_request(1'b1, {1'b0, addr}, len, t0);
    for (i = 0; i < len; i++)
    begin
      flash_wr_valid <= 1'b1;
      flash_wr_data  <= wr_bytes[i];
      flash_wr_last  <= (i == len - 1);
      @(posedge sys_clk);
    end
    flash_wr_valid <= 1'b0;
    flash_wr_last  <= 1'b0;
    wait_idle(t0, busy);
    assert (busy >= DATA_BUSY + `EE_BYTE_CYCLES * len)
    else
      halt_run($sformatf("error %s busy cycles: expected at least %0d, actual %0d",
                         name, DATA_BUSY + `EE_BYTE_CYCLES * len, busy));
    for (i = 0; i < len; i++)
      apply_write(addr + 16'(i), wr_bytes[i]);
    close_write();
  endtask

  task automatic read_bytes(input string name, input logic [15:0] addr, input int len);
    int t0;
    int busy;
    int n;
    int i;
    rd_q.delete();
    rd_last_q.delete();
    issue_request(1'b0, {1'b0, addr}, len, t0);
    wait_idle(t0, busy);
    check_equal({name, " busy cycles"}, DATA_BUSY + `EE_BYTE_CYCLES * len, busy);
    n = 0;
    while (rd_q.size() < len && n < `EE_BYTE_CYCLES)
    begin
      @(negedge sys_clk);
      n++;
    end
    repeat (2) @(negedge sys_clk);
    check_equal({name, " read count"}, len, rd_q.size());
    for (i = 0; i < len; i++)
    begin
      check_equal({name, " last flag"}, (i == len - 1), rd_last_q[i]);
      // bytes never stored hold no known value
      if (byte_known(addr + 16'(i)))
        check_equal({name, " data"}, expected_byte(addr + 16'(i)), rd_q[i]);
    end
  endtask

  initial
  begin
    #(CLK_PERIOD * (TX_TOTAL * (TX_CYCLES + 10) + 100));
    halt_run("timeout: the DUT did not finish all transactions in time");
  end

  initial
  begin
    logic [15:0] addr;
    logic [7:0]  st;
    int          len;
    int          idx;
    int          kind;
    int          r;
    int          i;
    void'($urandom(32'h9ee));
    sys_clk        = 1'b0;
    glbl_rst_n     = 1'b0;
    flash_rden     = 1'b0;
    flash_wren     = 1'b0;
    flash_addr     = '0;
    flash_length   = '0;
    flash_wr_data  = '0;
    flash_wr_valid = 1'b0;
    flash_wr_last  = 1'b0;
    cycle_cnt      = 0;
    clear_reference();
    repeat (5) @(posedge sys_clk);
    glbl_rst_n <= 1'b1;

    for (r = 0; r < 4; r++)
    begin
      addr         = WIN_BASE + 16'($urandom_range(55, 0));
      len          = $urandom_range(8, 1);
      used_addr[r] = addr;
      used_len[r]  = len;
      write_enable("write_enabled");
      write_bytes("write_enabled", addr, len);
      read_bytes("write_enabled", addr, len);
      for (i = 0; i < len; i++)
        check_equal("write_enabled readback", wr_bytes[i], rd_q[i]);
    end

    // latch is clear here, so these writes must not land
    for (r = 0; r < 3; r++)
    begin
      idx = $urandom_range(3, 0);
      write_bytes("write_protected", used_addr[idx], used_len[idx]);
      read_bytes("write_protected", used_addr[idx], used_len[idx]);
    end

    for (r = 0; r < 4; r++)
      read_bytes("read_last", WIN_BASE + 16'($urandom_range(55, 0)), $urandom_range(8, 1));

    write_enable("status_read");
    read_status("status_read", st);
    check_equal("status_read wel after enable", 1, st[1]);
    write_bytes("status_read", WIN_BASE + 16'($urandom_range(55, 0)), $urandom_range(8, 1));
    read_status("status_read", st);
    check_equal("status_read wel after write", 0, st[1]);
    check_equal("status_read wip after write", 1, st[0]);

    for (r = 0; r < 40; r++)
    begin
      kind = $urandom_range(3, 0);
      addr = WIN_BASE + 16'($urandom_range(55, 0));
      len  = $urandom_range(8, 1);
      case (kind)
        0: write_enable("ready_protocol");
        1: read_status("ready_protocol", st);
        2: write_bytes("ready_protocol", addr, len);
        default: read_bytes("ready_protocol", addr, len);
      endcase
    end

    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+verilog
+incdir+testbench
verilog/eeprom_pkg.sv
verilog/eeprom_req_decode.sv
verilog/eeprom_tx_fifo.sv
verilog/eeprom_sequencer.sv
verilog/eeprom_array.sv
verilog/eeprom_read_return.sv
verilog/eeprom_top.sv
testbench/eeprom_tb.sv
